/* hw/morse_pkg.sv */
/*
 * Morse LCD shared definitions
 * Symbol and state enums, LCD commands, code table and banner text
 */
`default_nettype none

package morse_pkg;

    // Symbol from keyer to decoder
    typedef enum logic [1:0] {
        SYM_DOT,
        SYM_DASH,
        SYM_END
    } sym_t;

    typedef logic [7:0] char_t;

    localparam int MAX_SYMBOLS = 5;

    // Symbol count and pattern, first symbol in the top used bit, dash is 1
    typedef logic [2:0] code_len_t;
    typedef logic [4:0] code_bits_t;

    localparam char_t CHAR_SPACE   = 8'h20;
    localparam char_t CHAR_UNKNOWN = 8'h3F;

    // ------------------------------------------------------------------
    // HD44780 interface
    // ------------------------------------------------------------------
    localparam int LCD_COLS = 16;

    typedef enum logic [3:0] {
        RESET1,
        RESET2,
        RESET3,
        FUNC_SET,
        DISPLAY_OFF,
        DISPLAY_CLEAR,
        DISPLAY_ON,
        MODE_SET,
        PRINT_CHAR,
        LINE2,
        RETURN_HOME,
        DROP_E,
        HOLD
    } lcd_state_t;

    // 8-bit bus, 2 lines, 5x8 font
    localparam char_t CMD_FUNC_SET    = 8'h38;
    localparam char_t CMD_DISPLAY_OFF = 8'h08;
    localparam char_t CMD_CLEAR       = 8'h01;
    // Display on, cursor off
    localparam char_t CMD_DISPLAY_ON  = 8'h0C;
    // Auto increment, no shift
    localparam char_t CMD_ENTRY_MODE  = 8'h06;
    localparam char_t CMD_LINE1       = 8'h80;
    localparam char_t CMD_LINE2       = 8'hC0;

    // Fixed second line, leftmost character in the top byte
    localparam logic [LCD_COLS*8-1:0] BANNER = "MORSE DECODER   ";

    // International code table, unknown patterns give '?'
    function automatic char_t morse_to_ascii(input code_len_t len, input code_bits_t bits);
        case ({len, bits})
            {3'd1, 5'b00000}: return "E";
            {3'd1, 5'b00001}: return "T";
            {3'd2, 5'b00000}: return "I";
            {3'd2, 5'b00001}: return "A";
            {3'd2, 5'b00010}: return "N";
            {3'd2, 5'b00011}: return "M";
            {3'd3, 5'b00000}: return "S";
            {3'd3, 5'b00001}: return "U";
            {3'd3, 5'b00010}: return "R";
            {3'd3, 5'b00011}: return "W";
            {3'd3, 5'b00100}: return "D";
            {3'd3, 5'b00101}: return "K";
            {3'd3, 5'b00110}: return "G";
            {3'd3, 5'b00111}: return "O";
            {3'd4, 5'b00000}: return "H";
            {3'd4, 5'b00001}: return "V";
            {3'd4, 5'b00010}: return "F";
            {3'd4, 5'b00100}: return "L";
            {3'd4, 5'b00110}: return "P";
            {3'd4, 5'b00111}: return "J";
            {3'd4, 5'b01000}: return "B";
            {3'd4, 5'b01001}: return "X";
            {3'd4, 5'b01010}: return "C";
            {3'd4, 5'b01011}: return "Y";
            {3'd4, 5'b01100}: return "Z";
            {3'd4, 5'b01101}: return "Q";
            {3'd5, 5'b01111}: return "1";
            {3'd5, 5'b00111}: return "2";
            {3'd5, 5'b00011}: return "3";
            {3'd5, 5'b00001}: return "4";
            {3'd5, 5'b00000}: return "5";
            {3'd5, 5'b10000}: return "6";
            {3'd5, 5'b11000}: return "7";
            {3'd5, 5'b11100}: return "8";
            {3'd5, 5'b11110}: return "9";
            {3'd5, 5'b11111}: return "0";
            default:          return CHAR_UNKNOWN;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/morse_keyer.sv */
/*
 * Morse keyer
 * Times the key in units and reports dots, dashes and letter ends
 */
`default_nettype none

module morse_keyer #(
    parameter int UNIT_CYCLES      = 40,
    parameter int DASH_UNITS       = 3,
    parameter int LETTER_GAP_UNITS = 3
) (
    input  wire logic            CLK_400HZ,
    input  wire logic            iRST_N,
    input  wire logic            key_down,
    output logic                 sym_valid,
    output morse_pkg::sym_t      sym
);

    localparam int DIV_W = (UNIT_CYCLES > 1) ? $clog2(UNIT_CYCLES) : 1;
    localparam int CNT_W = 8;

    logic [1:0]       key_sync;
    logic             key_s;
    logic [DIV_W-1:0] div_cnt;
    logic             unit_tick;
    logic [CNT_W-1:0] press_cnt;
    logic [CNT_W-1:0] gap_cnt;
    logic [CNT_W-1:0] gap_next;
    logic             letter_pending;

    assign key_s     = key_sync[1];
    assign unit_tick = (div_cnt == DIV_W'(UNIT_CYCLES - 1));
    // Gap length saturates during long idle periods
    assign gap_next  = (gap_cnt == '1) ? gap_cnt : gap_cnt + 1'b1;

    always_ff @(posedge CLK_400HZ or negedge iRST_N) begin
        if (!iRST_N) begin
            key_sync <= '0;
            div_cnt  <= '0;
        end else begin
            key_sync <= {key_sync[0], key_down};
            div_cnt  <= unit_tick ? '0 : div_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Press and gap measurement, sampled once per unit
    // ------------------------------------------------------------------
    always_ff @(posedge CLK_400HZ or negedge iRST_N) begin
        if (!iRST_N) begin
            press_cnt      <= '0;
            gap_cnt        <= '0;
            letter_pending <= 1'b0;
            sym_valid      <= 1'b0;
        end else begin
            sym_valid <= 1'b0;
            if (unit_tick) begin
                if (key_s) begin
                    if (press_cnt != '1) begin
                        press_cnt <= press_cnt + 1'b1;
                    end
                    gap_cnt <= '0;
                end else begin
                    gap_cnt <= gap_next;
                    if (press_cnt != '0) begin
                        // First silent unit closes the press
                        sym_valid      <= 1'b1;
                        press_cnt      <= '0;
                        letter_pending <= 1'b1;
                    end else if (letter_pending && gap_next >= CNT_W'(LETTER_GAP_UNITS)) begin
                        sym_valid      <= 1'b1;
                        letter_pending <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK_400HZ) begin
        if (unit_tick && !key_s) begin
            if (press_cnt != '0) begin
                sym <= (press_cnt >= CNT_W'(DASH_UNITS)) ? morse_pkg::SYM_DASH
                                                         : morse_pkg::SYM_DOT;
            end else begin
                sym <= morse_pkg::SYM_END;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/morse_tree_decoder.sv */
/*
 * Morse tree decoder
 * Collects the symbols of one letter and emits its ASCII code
 */
`default_nettype none

module morse_tree_decoder (
    input  wire logic              CLK_400HZ,
    input  wire logic              iRST_N,
    input  wire logic              sym_valid,
    input  wire morse_pkg::sym_t   sym,
    output logic                   char_valid,
    output morse_pkg::char_t       char
);

    // Position in the code tree: depth plus the path taken,
    // one bit per level, dash going right
    morse_pkg::code_len_t  code_len;
    morse_pkg::code_bits_t code_bits;
    logic                  code_bad;
    logic                  at_max_depth;
    logic                  is_dash;

    assign at_max_depth = (code_len == morse_pkg::code_len_t'(morse_pkg::MAX_SYMBOLS));
    assign is_dash      = (sym == morse_pkg::SYM_DASH);

    // ------------------------------------------------------------------
    // Tree walk
    // ------------------------------------------------------------------
    always_ff @(posedge CLK_400HZ or negedge iRST_N) begin
        if (!iRST_N) begin
            code_len   <= '0;
            code_bits  <= '0;
            code_bad   <= 1'b0;
            char_valid <= 1'b0;
        end else begin
            char_valid <= 1'b0;
            if (sym_valid) begin
                case (sym)
                    morse_pkg::SYM_DOT, morse_pkg::SYM_DASH: begin
                        if (at_max_depth) begin
                            // Deeper than any table entry
                            code_bad <= 1'b1;
                        end else begin
                            code_len  <= code_len + 1'b1;
                            code_bits <= {code_bits[morse_pkg::MAX_SYMBOLS-2:0], is_dash};
                        end
                    end
                    morse_pkg::SYM_END: begin
                        char_valid <= 1'b1;
                        // Back to the tree root for the next letter
                        code_len   <= '0;
                        code_bits  <= '0;
                        code_bad   <= 1'b0;
                    end
                    default: begin
                        code_bad <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Character lookup at the end of the letter
    always_ff @(posedge CLK_400HZ) begin
        if (sym_valid && sym == morse_pkg::SYM_END) begin
            if (code_bad) begin
                char <= morse_pkg::CHAR_UNKNOWN;
            end else begin
                char <= morse_pkg::morse_to_ascii(code_len, code_bits);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/display_buffer.sv */
/*
 * Display buffer
 * Shifting history of decoded characters plus the fixed banner line
 */
`default_nettype none

module display_buffer (
    input  wire logic              CLK_400HZ,
    input  wire logic              iRST_N,
    input  wire logic              clear,
    input  wire logic              char_valid,
    input  wire morse_pkg::char_t  char,
    input  wire logic [4:0]        char_index,
    output morse_pkg::char_t       char_data
);

    // Cell 0 is the leftmost column, newest character in the last cell
    morse_pkg::char_t hist [morse_pkg::LCD_COLS];

    always_ff @(posedge CLK_400HZ or negedge iRST_N) begin
        if (!iRST_N) begin
            for (int i = 0; i < morse_pkg::LCD_COLS; i++) begin
                hist[i] <= morse_pkg::CHAR_SPACE;
            end
        end else if (clear) begin
            for (int i = 0; i < morse_pkg::LCD_COLS; i++) begin
                hist[i] <= morse_pkg::CHAR_SPACE;
            end
        end else if (char_valid) begin
            for (int i = 0; i < morse_pkg::LCD_COLS - 1; i++) begin
                hist[i] <= hist[i+1];
            end
            hist[morse_pkg::LCD_COLS-1] <= char;
        end
    end

    // ------------------------------------------------------------------
    // Read port for the LCD driver
    // ------------------------------------------------------------------
    always_comb begin
        if (char_index[4]) begin
            // Line 2, banner stored with column 0 in the top byte
            char_data = morse_pkg::BANNER[{~char_index[3:0], 3'b000} +: 8];
        end else begin
            char_data = hist[char_index[3:0]];
        end
    end

endmodule

`default_nettype wire

/* hw/hd44780_driver.sv */
/*
 * HD44780 write-only driver
 * Runs the init command sequence, then refreshes both lines forever
 */
`default_nettype none

module hd44780_driver (
    input  wire logic              CLK_400HZ,
    input  wire logic              iRST_N,
    output logic [4:0]             char_index,
    input  wire morse_pkg::char_t  char_data,
    output logic                   lcd_rs,
    output logic                   lcd_e,
    output morse_pkg::char_t       lcd_data
);

    morse_pkg::lcd_state_t state;
    // State to enter once the current write has finished
    morse_pkg::lcd_state_t next_cmd;

    always_ff @(posedge CLK_400HZ or negedge iRST_N) begin
        if (!iRST_N) begin
            state      <= morse_pkg::RESET1;
            next_cmd   <= morse_pkg::RESET1;
            char_index <= '0;
            lcd_rs     <= 1'b0;
            lcd_e      <= 1'b0;
            lcd_data   <= '0;
        end else begin
            case (state)
                // ----------------------------------------------------------
                // Tail of every write: E falls, then bus held one cycle
                // ----------------------------------------------------------
                morse_pkg::DROP_E: begin
                    lcd_e <= 1'b0;
                    state <= morse_pkg::HOLD;
                end
                morse_pkg::HOLD: begin
                    state <= next_cmd;
                end

                // ----------------------------------------------------------
                // Any other state starts a write with E high
                // ----------------------------------------------------------
                default: begin
                    lcd_e  <= 1'b1;
                    lcd_rs <= 1'b0;
                    state  <= morse_pkg::DROP_E;
                    case (state)
                        morse_pkg::RESET1: begin
                            lcd_data   <= morse_pkg::CMD_FUNC_SET;
                            next_cmd   <= morse_pkg::RESET2;
                            char_index <= '0;
                        end
                        morse_pkg::RESET2: begin
                            lcd_data <= morse_pkg::CMD_FUNC_SET;
                            next_cmd <= morse_pkg::RESET3;
                        end
                        // Repeated function sets make a warm reset reliable
                        morse_pkg::RESET3: begin
                            lcd_data <= morse_pkg::CMD_FUNC_SET;
                            next_cmd <= morse_pkg::FUNC_SET;
                        end
                        morse_pkg::FUNC_SET: begin
                            lcd_data <= morse_pkg::CMD_FUNC_SET;
                            next_cmd <= morse_pkg::DISPLAY_OFF;
                        end
                        morse_pkg::DISPLAY_OFF: begin
                            lcd_data <= morse_pkg::CMD_DISPLAY_OFF;
                            next_cmd <= morse_pkg::DISPLAY_CLEAR;
                        end
                        morse_pkg::DISPLAY_CLEAR: begin
                            lcd_data <= morse_pkg::CMD_CLEAR;
                            next_cmd <= morse_pkg::DISPLAY_ON;
                        end
                        morse_pkg::DISPLAY_ON: begin
                            lcd_data <= morse_pkg::CMD_DISPLAY_ON;
                            next_cmd <= morse_pkg::MODE_SET;
                        end
                        morse_pkg::MODE_SET: begin
                            lcd_data <= morse_pkg::CMD_ENTRY_MODE;
                            next_cmd <= morse_pkg::RETURN_HOME;
                        end
                        morse_pkg::PRINT_CHAR: begin
                            lcd_rs     <= 1'b1;
                            lcd_data   <= char_data;
                            // Wraps from 31 back to column 0 of line 1
                            char_index <= char_index + 1'b1;
                            if (char_index == 5'd15) begin
                                next_cmd <= morse_pkg::LINE2;
                            end else if (char_index == 5'd31) begin
                                next_cmd <= morse_pkg::RETURN_HOME;
                            end else begin
                                next_cmd <= morse_pkg::PRINT_CHAR;
                            end
                        end
                        morse_pkg::LINE2: begin
                            lcd_data <= morse_pkg::CMD_LINE2;
                            next_cmd <= morse_pkg::PRINT_CHAR;
                        end
                        default: begin
                            // RETURN_HOME, start of a refresh pass
                            lcd_data <= morse_pkg::CMD_LINE1;
                            next_cmd <= morse_pkg::PRINT_CHAR;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/morse_lcd_top.sv */
/*
 * Morse to LCD top level
 * Keyer, decoder, history buffer and LCD driver
 */
`default_nettype none

module morse_lcd_top #(
    parameter int UNIT_CYCLES      = 40,
    parameter int DASH_UNITS       = 3,
    parameter int LETTER_GAP_UNITS = 3
) (
    input  wire logic         CLK_400HZ,
    input  wire logic         iRST_N,
    input  wire logic         key_down,
    input  wire logic         clear,
    output logic              lcd_rs,
    output logic              lcd_e,
    output morse_pkg::char_t  lcd_data
);

    logic             sym_valid;
    morse_pkg::sym_t  sym;
    logic             char_valid;
    morse_pkg::char_t char;
    logic [4:0]       char_index;
    morse_pkg::char_t char_data;

    morse_keyer #(
        .UNIT_CYCLES      (UNIT_CYCLES),
        .DASH_UNITS       (DASH_UNITS),
        .LETTER_GAP_UNITS (LETTER_GAP_UNITS)
    ) u_morse_keyer (
        .CLK_400HZ (CLK_400HZ),
        .iRST_N    (iRST_N),
        .key_down  (key_down),
        .sym_valid (sym_valid),
        .sym       (sym)
    );

    morse_tree_decoder u_morse_tree_decoder (
        .CLK_400HZ  (CLK_400HZ),
        .iRST_N     (iRST_N),
        .sym_valid  (sym_valid),
        .sym        (sym),
        .char_valid (char_valid),
        .char       (char)
    );

    display_buffer u_display_buffer (
        .CLK_400HZ  (CLK_400HZ),
        .iRST_N     (iRST_N),
        .clear      (clear),
        .char_valid (char_valid),
        .char       (char),
        .char_index (char_index),
        .char_data  (char_data)
    );

    hd44780_driver u_hd44780_driver (
        .CLK_400HZ  (CLK_400HZ),
        .iRST_N     (iRST_N),
        .char_index (char_index),
        .char_data  (char_data),
        .lcd_rs     (lcd_rs),
        .lcd_e      (lcd_e),
        .lcd_data   (lcd_data)
    );

endmodule

`default_nettype wire

/* test/tb_morse_lcd.sv */
/*
 * Testbench for the Morse to LCD top level
 * Keys letters, models the LCD screen and checks it against a reference
 */
`default_nettype none

module tb_morse_lcd;

    localparam int UNIT = 4;

    logic       CLK_400HZ = 1'b0;
    logic       iRST_N;
    logic       key_down;
    logic       clear;
    logic       lcd_rs;
    logic       lcd_e;
    logic [7:0] lcd_data;

    // Screen model and command log filled by the bus monitor
    logic [7:0] screen [32];
    logic [4:0] scr_addr = 5'd0;
    logic [7:0] cmd_log [$];
    int         line1_passes = 0;

    // Expected history with the oldest character first
    logic [7:0]  ref_hist [$];
    logic [31:0] lfsr = 32'hb1ba;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start_errors = 0;

    logic [7:0] exp_init [8] = '{8'h38, 8'h38, 8'h38, 8'h38, 8'h08, 8'h01, 8'h0C, 8'h06};

    string alphabet = "ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789";
    string banner   = "MORSE DECODER   ";
    // International code in the same order as alphabet
    string morse_codes [36] = '{
        ".-", "-...", "-.-.", "-..", ".", "..-.", "--.", "....", "..", ".---",
        "-.-", ".-..", "--", "-.", "---", ".--.", "--.-", ".-.", "...", "-",
        "..-", "...-", ".--", "-..-", "-.--", "--..",
        "-----", ".----", "..---", "...--", "....-", ".....", "-....", "--...",
        "---..", "----."
    };

    morse_lcd_top #(
        .UNIT_CYCLES (UNIT)
    ) u_morse_lcd_top (
        .CLK_400HZ (CLK_400HZ),
        .iRST_N    (iRST_N),
        .key_down  (key_down),
        .clear     (clear),
        .lcd_rs    (lcd_rs),
        .lcd_e     (lcd_e),
        .lcd_data  (lcd_data)
    );

    always #5 CLK_400HZ = ~CLK_400HZ;

    // ------------------------------------------------------------------
    // LCD bus monitor
    // ------------------------------------------------------------------
    // The panel latches on the falling edge of E
    always @(negedge lcd_e) begin
        if (iRST_N === 1'b1) begin
            if (lcd_rs === 1'b0) begin
                cmd_log.push_back(lcd_data);
                if (lcd_data == 8'h80) begin
                    scr_addr = 5'd0;
                end else if (lcd_data == 8'hC0) begin
                    scr_addr = 5'd16;
                end
            end else begin
                screen[scr_addr] = lcd_data;
                // Last column of line 1 closes a refresh pass
                if (scr_addr == 5'd15) begin
                    line1_passes++;
                end
                scr_addr = scr_addr + 5'd1;
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Reference decode of a dot/dash string
    // Unknown codes give '?'
    function automatic logic [7:0] ref_decode(input string code);
        for (int i = 0; i < 36; i++) begin
            if (morse_codes[i] == code) begin
                return alphabet[i];
            end
        end
        return "?";
    endfunction

    task automatic ref_push(input logic [7:0] c);
        ref_hist.delete(0);
        ref_hist.push_back(c);
    endtask

    task automatic ref_blank();
        ref_hist.delete();
        for (int i = 0; i < 16; i++) begin
            ref_hist.push_back(8'h20);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK_400HZ);
        #1;
    endtask

    // Dot 1 unit, dash 3 units, 1 unit between symbols, 4 after the letter
    task automatic key_letter(input string code);
        for (int i = 0; i < code.len(); i++) begin
            key_down = 1'b1;
            wait_cycles(code[i] == "-" ? 3 * UNIT : UNIT);
            key_down = 1'b0;
            wait_cycles(i == code.len() - 1 ? 4 * UNIT : UNIT);
        end
        ref_push(ref_decode(code));
    endtask

    task automatic key_char(input int idx);
        key_letter(morse_codes[idx]);
    endtask

    task automatic finish_run();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_line1_passes(input int n);
        int target;
        int waited;
        target = line1_passes + n;
        waited = 0;
        while (line1_passes < target) begin
            @(negedge CLK_400HZ);
            waited++;
            if (waited > 150 * n) begin
                $display("ERROR t=%0t: no completed line 1 refresh within %0d cycles",
                         $time, 150 * n);
                errors++;
                finish_run();
            end
        end
        @(posedge CLK_400HZ);
        #1;
    endtask

    task automatic check_byte(input string what, input int idx,
                              input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s[%0d]: got 8'h%02h, expected 8'h%02h",
                     $time, what, idx, got, exp);
            errors++;
        end
    endtask

    task automatic compare_screen();
        for (int i = 0; i < 16; i++) begin
            check_byte("screen_line1", i, screen[i], ref_hist[i]);
        end
        for (int i = 0; i < 16; i++) begin
            check_byte("screen_line2", i, screen[16 + i], banner[i]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - test_start_errors);
        end else begin
            $display("test %s ok", name);
        end
        test_start_errors = errors;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        int v;
        key_down = 1'b0;
        clear    = 1'b0;
        iRST_N   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            screen[i] = 8'h00;
        end
        ref_blank();
        repeat (10) @(posedge CLK_400HZ);
        #1;
        iRST_N = 1'b1;

        wait_line1_passes(2);
        if (cmd_log.size() < 8) begin
            $display("ERROR t=%0t: only %0d LCD commands seen after reset", $time, cmd_log.size());
            errors++;
        end else begin
            for (int i = 0; i < 8; i++) begin
                check_byte("init_cmd", i, cmd_log[i], exp_init[i]);
            end
        end
        compare_screen();
        end_test("init");

        key_letter("...");
        key_letter("---");
        key_letter("...");
        key_letter(".");
        key_letter("-");
        wait_line1_passes(2);
        compare_screen();
        end_test("letters");

        for (int i = 26; i < 36; i++) begin
            key_char(i);
        end
        // All ten digits are still on line 1 here
        wait_line1_passes(2);
        compare_screen();
        for (int i = 0; i < 20; i++) begin
            take_bits(6, v);
            key_char(v % 36);
        end
        wait_line1_passes(2);
        compare_screen();
        end_test("digits_random");

        key_letter("..--");
        key_letter("......");
        wait_line1_passes(2);
        compare_screen();
        end_test("invalid");

        clear = 1'b1;
        wait_cycles(1);
        clear = 1'b0;
        ref_blank();
        wait_line1_passes(2);
        compare_screen();
        key_letter("-.-");
        key_letter("--...");
        wait_line1_passes(2);
        compare_screen();
        end_test("clear");

        finish_run();
    end

endmodule

`default_nettype wire

/* morse_lcd.f */
hw/morse_pkg.sv
hw/morse_keyer.sv
hw/morse_tree_decoder.sv
hw/display_buffer.sv
hw/hd44780_driver.sv
hw/morse_lcd_top.sv
test/tb_morse_lcd.sv

/* Makefile */
# Verilator flow for the Morse to LCD project

TOP = tb_morse_lcd

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f morse_lcd.f --top-module morse_lcd_top
	verilator --lint-only -Wall --timing -f morse_lcd.f --top-module $(TOP)

# Pass or fail is read from the simulation log
sim:
	verilator --binary --timing -f morse_lcd.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
